// File: common/router_macros.svh
/* Router register slave widths */

`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////

// Register and AXI data width
`define ROUTER_DATA_W 32

// AXI byte address width, covers eight word slots
`define ROUTER_ADDR_W 5

// One strobe bit per data byte
`define ROUTER_STRB_W 4

////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////

// First address bit of the word index
`define ROUTER_ADDR_LSB 2

// Implemented registers, slot 7 is a hole
`define ROUTER_NUM_REGS 7

`endif

// File: common/axil_pkg.sv
/* AXI4-Lite bus types */

`include "router_macros.svh"

`default_nettype none

package axil_pkg;

  ////////////////////////////////////////////////////////////
  // Response codes
  ////////////////////////////////////////////////////////////

  // EXOKAY and DECERR are never produced by this slave
  typedef enum logic [1:0]
  {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  ////////////////////////////////////////////////////////////
  // Payload types
  ////////////////////////////////////////////////////////////

  // Byte address as seen on AWADDR and ARADDR
  typedef logic [`ROUTER_ADDR_W-1:0] axil_addr_t;

  // Data word on WDATA and RDATA
  typedef logic [`ROUTER_DATA_W-1:0] axil_data_t;

  // Byte lane enables on WSTRB
  typedef logic [`ROUTER_STRB_W-1:0] axil_strb_t;

endpackage

`default_nettype wire

// File: common/router_regs_pkg.sv
/* Router register map types */

`include "router_macros.svh"

`default_nettype none

package router_regs_pkg;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  // Word index, byte address with the lane bits stripped
  typedef logic [`ROUTER_ADDR_W-`ROUTER_ADDR_LSB-1:0] reg_idx_t;

  // Router command word
  localparam reg_idx_t REG_CMD       = 3'd0;
  // First stream identifier
  localparam reg_idx_t REG_STRM_ID_0 = 3'd1;
  // Second stream identifier
  localparam reg_idx_t REG_STRM_ID_1 = 3'd2;

  ////////////////////////////////////////////////////////////
  // Internal transfer structs
  ////////////////////////////////////////////////////////////

  // One register write, en is a single-cycle strobe
  typedef struct packed
  {
    logic                en;
    reg_idx_t            idx;
    axil_pkg::axil_data_t data;
    axil_pkg::axil_strb_t strb;
  } reg_wr_t;

  // Settings consumed by the packet router
  typedef struct packed
  {
    axil_pkg::axil_data_t cmd;
    axil_pkg::axil_data_t strm_id_0;
    axil_pkg::axil_data_t strm_id_1;
  } router_cfg_t;

endpackage

`default_nettype wire

// File: axil_slave/axil_write_channel.sv
/* AXI4-Lite write channel */

`include "router_macros.svh"

`default_nettype none

module axil_write_channel
  import axil_pkg::*, router_regs_pkg::*;
(
  input  wire        S_AXI_ACLK,
  input  wire        S_AXI_ARESETN,
  // Write address channel
  input  axil_addr_t awaddr,
  input  wire        awvalid,
  output logic       awready,
  // Write data channel
  input  axil_data_t wdata,
  input  axil_strb_t wstrb,
  input  wire        wvalid,
  output logic       wready,
  // Write response channel
  output axil_resp_e bresp,
  output logic       bvalid,
  input  wire        bready,
  // Request towards the register bank
  output reg_wr_t    wr_req
);

  // Address and data both present, nothing in flight
  logic     wr_start;
  // AW and W complete together in this cycle
  logic     wr_hs;
  // Word index of the accepted address
  reg_idx_t wr_idx;

  ////////////////////////////////////////////////////////////
  // Address and data acceptance
  ////////////////////////////////////////////////////////////

  // Both readies low means no handshake is under way
  // A pending response holds off the next write
  assign wr_start = awvalid && wvalid && !awready && !wready && !bvalid;
  assign wr_hs    = awready && awvalid && wready && wvalid;

  // Readies pulse together for exactly one cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
    end
    else
    begin
      awready <= wr_start;
      wready  <= wr_start;
    end
  end

  // Keep only the word bits, the bank never sees byte addresses
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      wr_idx <= '0;
    else if (wr_start)
      wr_idx <= awaddr[`ROUTER_ADDR_W-1:`ROUTER_ADDR_LSB];
  end

  ////////////////////////////////////////////////////////////
  // Register write request
  ////////////////////////////////////////////////////////////

  // Data and strobe are stable on the bus during the handshake
  always_comb
  begin
    wr_req.en   = wr_hs;
    wr_req.idx  = wr_idx;
    wr_req.data = wdata;
    wr_req.strb = wstrb;
  end

  ////////////////////////////////////////////////////////////
  // Write response
  ////////////////////////////////////////////////////////////

  // BVALID rises with the register update, held until BREADY
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      bvalid <= 1'b0;
    else if (wr_hs)
      bvalid <= 1'b1;
    else if (bready)
      bvalid <= 1'b0;
  end

  // Every register write completes without error
  assign bresp = OKAY;

endmodule

`default_nettype wire

// File: axil_slave/axil_read_channel.sv
/* AXI4-Lite read channel */

`include "router_macros.svh"

`default_nettype none

module axil_read_channel
  import axil_pkg::*, router_regs_pkg::*;
(
  input  wire        S_AXI_ACLK,
  input  wire        S_AXI_ARESETN,
  // Read address channel
  input  axil_addr_t araddr,
  input  wire        arvalid,
  output logic       arready,
  // Read data channel
  output axil_data_t rdata,
  output axil_resp_e rresp,
  output logic       rvalid,
  input  wire        rready,
  // Register bank lookup
  output reg_idx_t   rd_idx,
  input  axil_data_t rd_data
);

  // AR handshake completes in this cycle
  logic ar_hs;

  assign ar_hs = arready && arvalid;

  ////////////////////////////////////////////////////////////
  // Address acceptance
  ////////////////////////////////////////////////////////////

  // One address at a time, nothing while RDATA waits
  // rd_idx settles during the ARREADY cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready <= 1'b0;
      rd_idx  <= '0;
    end
    else if (arvalid && !arready && !rvalid)
    begin
      arready <= 1'b1;
      rd_idx  <= araddr[`ROUTER_ADDR_W-1:`ROUTER_ADDR_LSB];
    end
    else
      arready <= 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Read data and response
  ////////////////////////////////////////////////////////////

  // Sample the bank on the handshake edge
  // A write landing on that same edge is not seen
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end
    else if (ar_hs)
    begin
      rvalid <= 1'b1;
      rdata  <= rd_data;
    end
    else if (rready)
      rvalid <= 1'b0;
  end

  // Reads never fail, the hole at slot 7 returns zero
  assign rresp = OKAY;

endmodule

`default_nettype wire

// File: verilog/router_reg_bank.sv
/* Router control register bank */

`include "router_macros.svh"

`default_nettype none

module router_reg_bank
  import axil_pkg::*, router_regs_pkg::*;
(
  input  wire         S_AXI_ACLK,
  input  wire         S_AXI_ARESETN,
  // Write request from the write channel
  input  reg_wr_t     wr_req,
  // Lookup from the read channel
  input  reg_idx_t    rd_idx,
  output axil_data_t  rd_data,
  // Settings for the packet router
  output router_cfg_t cfg
);

  // Bits per strobe lane
  localparam int LANE_W = `ROUTER_DATA_W / `ROUTER_STRB_W;

  // Implemented registers, slots 0 to 6
  axil_data_t regs [`ROUTER_NUM_REGS];

  // Write targets an implemented slot
  logic wr_hit;
  // Read targets an implemented slot
  logic rd_hit;

  assign wr_hit = wr_req.en && (wr_req.idx < `ROUTER_NUM_REGS);
  assign rd_hit = rd_idx < `ROUTER_NUM_REGS;

  ////////////////////////////////////////////////////////////
  // Register write
  ////////////////////////////////////////////////////////////

  // Bytes merge one lane at a time under WSTRB
  // Unstrobed lanes keep their old value
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < `ROUTER_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_hit)
    begin
      for (int b = 0; b < `ROUTER_STRB_W; b++)
      begin
        if (wr_req.strb[b])
          regs[wr_req.idx][b*LANE_W +: LANE_W] <= wr_req.data[b*LANE_W +: LANE_W];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////////////////////////

  // Whole array is read, so every slot is in the decode
  // Slot 7 falls through to zero
  always_comb
  begin
    rd_data = '0;
    if (rd_hit)
      rd_data = regs[rd_idx];
  end

  ////////////////////////////////////////////////////////////
  // Router configuration
  ////////////////////////////////////////////////////////////

  // Straight from the flops, new values show with BVALID
  // Registers 3 to 6 are scratch and drive nothing
  always_comb
  begin
    cfg.cmd       = regs[REG_CMD];
    cfg.strm_id_0 = regs[REG_STRM_ID_0];
    cfg.strm_id_1 = regs[REG_STRM_ID_1];
  end

endmodule

`default_nettype wire

// File: verilog/vita49_router_if.sv
/* VITA-49 router control slave */

`default_nettype none

module vita49_router_if
  import axil_pkg::*, router_regs_pkg::*;
(
  ////////////////////////////////////////////////////////////
  // Clock and reset
  ////////////////////////////////////////////////////////////
  input  wire        S_AXI_ACLK,
  input  wire        S_AXI_ARESETN,

  ////////////////////////////////////////////////////////////
  // AXI4-Lite slave port
  ////////////////////////////////////////////////////////////
  // Write address
  input  axil_addr_t S_AXI_AWADDR,
  input  wire        S_AXI_AWVALID,
  output logic       S_AXI_AWREADY,
  // Write data
  input  axil_data_t S_AXI_WDATA,
  input  axil_strb_t S_AXI_WSTRB,
  input  wire        S_AXI_WVALID,
  output logic       S_AXI_WREADY,
  // Write response
  output axil_resp_e S_AXI_BRESP,
  output logic       S_AXI_BVALID,
  input  wire        S_AXI_BREADY,
  // Read address
  input  axil_addr_t S_AXI_ARADDR,
  input  wire        S_AXI_ARVALID,
  output logic       S_AXI_ARREADY,
  // Read data
  output axil_data_t S_AXI_RDATA,
  output axil_resp_e S_AXI_RRESP,
  output logic       S_AXI_RVALID,
  input  wire        S_AXI_RREADY,

  ////////////////////////////////////////////////////////////
  // Router configuration
  ////////////////////////////////////////////////////////////
  output axil_data_t cmd,
  output axil_data_t strm_id_0,
  output axil_data_t strm_id_1
);

  // Write request into the bank
  reg_wr_t     wr_req;
  // Read lookup
  reg_idx_t    rd_idx;
  axil_data_t  rd_data;
  // Bank outputs for the router
  router_cfg_t cfg;

  // AW, W and B channels
  axil_write_channel axil_write_channel_i
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .wr_req        (wr_req)
  );

  // AR and R channels
  axil_read_channel axil_read_channel_i
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rdata         (S_AXI_RDATA),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  // Seven registers behind both channels
  router_reg_bank router_reg_bank_i
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_req        (wr_req),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .cfg           (cfg)
  );

  // Flat ports towards the router
  assign cmd       = cfg.cmd;
  assign strm_id_0 = cfg.strm_id_0;
  assign strm_id_1 = cfg.strm_id_1;

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
/* Testbench clock and reset */

`default_nettype none

module tb_clock_gen
(
  output logic S_AXI_ACLK,
  output logic S_AXI_ARESETN
);

  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #10 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // Reset held over three rising edges, released with the stimulus skew
  initial
  begin
    S_AXI_ARESETN = 1'b0;
    repeat (3) @(posedge S_AXI_ACLK);
    #2;
    S_AXI_ARESETN = 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/vita49_router_properties.sv
/* Router slave handshake assertions */

`default_nettype none

module vita49_router_properties
  import axil_pkg::*;
(
  input wire        S_AXI_ACLK,
  input wire        S_AXI_ARESETN,
  input wire        S_AXI_AWREADY,
  input wire        S_AXI_WREADY,
  input wire        S_AXI_BVALID,
  input wire        S_AXI_BREADY,
  input axil_resp_e S_AXI_BRESP,
  input wire        S_AXI_RVALID,
  input wire        S_AXI_RREADY,
  input axil_data_t S_AXI_RDATA,
  input axil_resp_e S_AXI_RRESP
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////////////////////////

  // Address and data are accepted together
  ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY == S_AXI_WREADY) else $error("AWREADY and WREADY differ");

  // Single-cycle ready pulse
  aw_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY |=> !S_AXI_AWREADY) else $error("AWREADY high for two cycles");

  // Response waits for the master
  b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID) else $error("BVALID dropped early");

  ////////////////////////////////////////////////////////////
  // Read channel and response codes
  ////////////////////////////////////////////////////////////

  // Data frozen while the master stalls
  r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
    else $error("RVALID or RDATA changed before RREADY");

  b_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID |-> S_AXI_BRESP == OKAY) else $error("BRESP is not OKAY");

  r_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID |-> S_AXI_RRESP == OKAY) else $error("RRESP is not OKAY");

endmodule

`default_nettype wire

// File: verif/tb_checker.sv
/* Register slave scoreboard */

`include "router_macros.svh"

`default_nettype none

module tb_checker
  import axil_pkg::*, router_regs_pkg::*;
(
  input wire        S_AXI_ACLK,
  input wire        S_AXI_ARESETN,
  input axil_addr_t S_AXI_AWADDR,
  input wire        S_AXI_AWVALID,
  input wire        S_AXI_AWREADY,
  input axil_data_t S_AXI_WDATA,
  input axil_strb_t S_AXI_WSTRB,
  input wire        S_AXI_WVALID,
  input wire        S_AXI_WREADY,
  input axil_resp_e S_AXI_BRESP,
  input wire        S_AXI_BVALID,
  input wire        S_AXI_BREADY,
  input axil_addr_t S_AXI_ARADDR,
  input wire        S_AXI_ARVALID,
  input wire        S_AXI_ARREADY,
  input axil_data_t S_AXI_RDATA,
  input axil_resp_e S_AXI_RRESP,
  input wire        S_AXI_RVALID,
  input wire        S_AXI_RREADY,
  input axil_data_t cmd,
  input axil_data_t strm_id_0,
  input axil_data_t strm_id_1
);

  timeunit 1ns;
  timeprecision 100ps;

  // Shadow of the register map, slot 7 included
  axil_data_t shadow [8];
  // Expected RDATA, queued at the AR handshake
  axil_data_t rd_expect [$];
  string      test_name;
  int         test_errors;
  int         error_count;
  int         test_count;
  int         check_count;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Byte lanes with a strobe take the new data
  function automatic axil_data_t merge_bytes(input axil_data_t old, input axil_data_t data,
                                             input axil_strb_t strb);
    axil_data_t res;
    res = old;
    for (int b = 0; b < `ROUTER_STRB_W; b++)
    begin
      if (strb[b])
        res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  // Unimplemented slot reads as zero
  function automatic axil_data_t expected_read(input reg_idx_t idx);
    if (idx >= `ROUTER_NUM_REGS)
      return '0;
    return shadow[idx];
  endfunction

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic compare(input string what, input axil_data_t exp, input axil_data_t act);
    check_count++;
    if (exp !== act)
    begin
      test_errors++;
      error_count++;
      $display("Fail %s: %s expected %08h actual %08h", test_name, what, exp, act);
    end
  endtask

  task automatic report(input string msg);
    test_errors++;
    error_count++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  // Router outputs follow shadow words 0 to 2
  task automatic end_test();
    compare("cmd", shadow[REG_CMD], cmd);
    compare("strm_id_0", shadow[REG_STRM_ID_0], strm_id_0);
    compare("strm_id_1", shadow[REG_STRM_ID_1], strm_id_1);
    test_count++;
    if (test_errors == 0)
      $display("Test %s passed", test_name);
    else
      $display("Test %s failed with %0d errors", test_name, test_errors);
  endtask

  task automatic report_counts();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
  endtask

  ////////////////////////////////////////////////////////////
  // Bus monitor
  ////////////////////////////////////////////////////////////

  // Read side first, so a same-edge write is not seen by the read
  always @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      rd_expect.delete();
      for (int i = 0; i < 8; i++)
        shadow[i] = '0;
    end
    else
    begin
      if (S_AXI_ARVALID && S_AXI_ARREADY)
      begin
        if (S_AXI_RVALID)
          report("read address accepted while read data was pending");
        rd_expect.push_back(expected_read(S_AXI_ARADDR[`ROUTER_ADDR_W-1:`ROUTER_ADDR_LSB]));
      end
      if (S_AXI_RVALID && S_AXI_RREADY)
      begin
        if (rd_expect.size() == 0)
          report("read data returned without a read request");
        else
          compare("RDATA", rd_expect.pop_front(), S_AXI_RDATA);
        compare("RRESP", 32'(OKAY), 32'(S_AXI_RRESP));
      end
      if (S_AXI_BVALID && S_AXI_BREADY)
        compare("BRESP", 32'(OKAY), 32'(S_AXI_BRESP));
      // AW and W always complete on the same edge here
      if (S_AXI_AWVALID && S_AXI_AWREADY && S_AXI_WVALID && S_AXI_WREADY)
      begin
        if (S_AXI_BVALID)
          report("write accepted while the write response was pending");
        if (S_AXI_AWADDR[`ROUTER_ADDR_W-1:`ROUTER_ADDR_LSB] < `ROUTER_NUM_REGS)
          shadow[S_AXI_AWADDR[`ROUTER_ADDR_W-1:`ROUTER_ADDR_LSB]] =
            merge_bytes(shadow[S_AXI_AWADDR[`ROUTER_ADDR_W-1:`ROUTER_ADDR_LSB]],
                        S_AXI_WDATA, S_AXI_WSTRB);
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
/* Router register slave testbench */

`include "router_macros.svh"

`default_nettype none

module tb_top
  import axil_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic       S_AXI_ACLK;
  logic       S_AXI_ARESETN;
  axil_addr_t S_AXI_AWADDR;
  logic       S_AXI_AWVALID;
  logic       S_AXI_AWREADY;
  axil_data_t S_AXI_WDATA;
  axil_strb_t S_AXI_WSTRB;
  logic       S_AXI_WVALID;
  logic       S_AXI_WREADY;
  axil_resp_e S_AXI_BRESP;
  logic       S_AXI_BVALID;
  logic       S_AXI_BREADY;
  axil_addr_t S_AXI_ARADDR;
  logic       S_AXI_ARVALID;
  logic       S_AXI_ARREADY;
  axil_data_t S_AXI_RDATA;
  axil_resp_e S_AXI_RRESP;
  logic       S_AXI_RVALID;
  logic       S_AXI_RREADY;
  axil_data_t cmd;
  axil_data_t strm_id_0;
  axil_data_t strm_id_1;
  // Set by the first wait that runs out
  logic       timed_out = 1'b0;

  tb_clock_gen tb_clock_gen_i (.*);
  vita49_router_if vita49_router_if_i (.*);
  tb_checker tb_checker_i (.*);

  bind vita49_router_if vita49_router_properties vita49_router_properties_i (.*);

  ////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////

  // Inputs change 2 ns after the rising edge
  task automatic tick();
    @(posedge S_AXI_ACLK);
    #2;
  endtask

  function automatic logic pick(input int sel);
    case (sel)
      0: return S_AXI_AWREADY;
      1: return S_AXI_BVALID;
      2: return S_AXI_ARREADY;
      3: return S_AXI_RVALID;
      default: return S_AXI_ARESETN;
    endcase
  endfunction

  task automatic wait_for(input int sel, input string what);
    int n;
    n = 0;
    while (!pick(sel) && n < 50 && !timed_out)
    begin
      tick();
      n++;
    end
    if (!pick(sel) && !timed_out)
    begin
      timed_out = 1'b1;
      $display("Timeout: %s did not rise within 50 cycles", what);
    end
  endtask

  // Valids stay up during a B stall as a second request
  task automatic write_reg(input int idx, input axil_data_t data, input axil_strb_t strb,
                           input int stall);
    S_AXI_AWADDR  = axil_addr_t'(idx << `ROUTER_ADDR_LSB);
    S_AXI_WDATA   = data;
    S_AXI_WSTRB   = strb;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    wait_for(0, "AWREADY");
    tick();
    repeat (stall) tick();
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    wait_for(1, "BVALID");
    S_AXI_BREADY = 1'b1;
    tick();
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic read_reg(input int idx, input int stall);
    S_AXI_ARADDR  = axil_addr_t'(idx << `ROUTER_ADDR_LSB);
    S_AXI_ARVALID = 1'b1;
    wait_for(2, "ARREADY");
    tick();
    repeat (stall) tick();
    S_AXI_ARVALID = 1'b0;
    wait_for(3, "RVALID");
    S_AXI_RREADY = 1'b1;
    tick();
    S_AXI_RREADY = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int idx;
    void'($urandom(32'h98d6_ef63));
    S_AXI_AWADDR  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    tick();
    wait_for(4, "reset release");

    tb_checker_i.start_test("reset_values");
    for (int i = 0; i < 8; i++)
      read_reg(i, 0);
    tb_checker_i.end_test();

    tb_checker_i.start_test("full_strobe");
    for (int i = 0; i < `ROUTER_NUM_REGS; i++)
    begin
      write_reg(i, $urandom, 4'hf, 0);
      read_reg(i, 0);
    end
    tb_checker_i.end_test();

    tb_checker_i.start_test("byte_strobe");
    repeat (16)
    begin
      idx = $urandom_range(6, 0);
      write_reg(idx, $urandom, 4'($urandom_range(15, 0)), 0);
      read_reg(idx, 0);
    end
    tb_checker_i.end_test();

    // Outputs are compared against the shadow in end_test
    tb_checker_i.start_test("config_outputs");
    for (int i = 0; i < 3; i++)
      write_reg(i, $urandom, 4'hf, 0);
    tb_checker_i.end_test();

    tb_checker_i.start_test("slot_7");
    write_reg(7, $urandom, 4'hf, 0);
    for (int i = 0; i < 8; i++)
      read_reg(i, 0);
    tb_checker_i.end_test();

    tb_checker_i.start_test("back_pressure");
    repeat (8)
    begin
      idx = $urandom_range(6, 0);
      write_reg(idx, $urandom, 4'($urandom_range(15, 0)), $urandom_range(10, 1));
      read_reg(idx, $urandom_range(10, 1));
    end
    tb_checker_i.end_test();

    tb_checker_i.report_counts();
    if (tb_checker_i.error_count == 0 && !timed_out)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/axil_pkg.sv
common/router_regs_pkg.sv
axil_slave/axil_write_channel.sv
axil_slave/axil_read_channel.sv
verilog/router_reg_bank.sv
verilog/vita49_router_if.sv
verif/tb_clock_gen.sv
verif/vita49_router_properties.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the router register slave testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f compile.f --top-module tb_top -o tb_top_sim

# A failing simulation is judged by the search below
output=$(./obj_dir/tb_top_sim) || true
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
